//--- files.f
+incdir+include
source/ecc_pkg.sv
source/secded_enc.sv
source/secded_dec.sv
source/ecc_initiator_bridge.sv
source/ecc_target_bridge.sv
source/ecc_err_regs.sv
source/tcdm_bank.sv
source/tcdm_ecc_top.sv
sim/tb_clk_gen.sv
sim/tb_tcdm_ecc.sv

//--- include/ecc_defines.svh
// width macros of the ECC-protected TCDM path, included by every file that sizes a field
`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

// data word, split into independently protected chunks
`define ECC_DW       64
`define ECC_CHUNK    32
`define ECC_NCHUNK   2

// request metadata is {add, wen, be}
`define ECC_AW       10
`define ECC_BW       8
`define ECC_METAW    19

// Hamming bits plus one overall parity bit
`define ECC_EW_CHUNK 7
`define ECC_EW_META  6

`endif

//--- sim/tb_clk_gen.sv
// testbench clock and reset source, 10 ns clock with reset held low for 16 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

//--- sim/tb_tcdm_ecc.sv
// directed tests that drive the ECC-protected TCDM path from tb_tcdm_ecc as the simulation top
`timescale 1ns/1ps
`include "ecc_defines.svh"

module tb_tcdm_ecc;

  import ecc_pkg::*;

  // about 40 transactions of 3 to 4 cycles, register accesses, reset and stalls, with margin
  localparam int CYCLE_LIMIT = 2000;

  logic        clk;
  logic        arst_n;
  core_req_t   req;
  logic        req_valid;
  logic        req_ready;
  core_rsp_t   rsp;
  logic        rsp_valid;
  logic        rsp_ready;
  reg_req_t    reg_req;
  logic        reg_valid;
  logic [31:0] reg_rdata;

  logic [`ECC_DW-1:0] model_mem [1024];
  integer             seed;
  int                 cycles = 0;
  int                 error_count = 0;
  int                 tests_passed = 0;
  int                 tests_failed = 0;

  tb_clk_gen i_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  tcdm_ecc_top dut (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .req_i       ( req       ),
    .req_valid_i ( req_valid ),
    .req_ready_o ( req_ready ),
    .rsp_o       ( rsp       ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_ready_i ( rsp_ready ),
    .reg_req_i   ( reg_req   ),
    .reg_valid_i ( reg_valid ),
    .reg_rdata_o ( reg_rdata )
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic core_req_t make_req(input logic [`ECC_AW-1:0] add, input logic wen,
                                         input logic [7:0] be, input logic [63:0] data);
    core_req_t r;
    r.add  = add;
    r.wen  = wen;
    r.be   = be;
    r.data = data;
    return r;
  endfunction

  function automatic core_rsp_t make_rsp(input logic [63:0] data, input rsp_opc_e opc);
    core_rsp_t r;
    r.r_data = data;
    r.r_opc  = opc;
    return r;
  endfunction

  // bytes with a set enable take the new value
  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                              input logic [63:0] new_w, input logic [7:0] be);
    logic [63:0] w;
    w = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic check_rsp(input string what, input core_rsp_t got, input core_rsp_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s data %h opc %0d, expected data %h opc %0d", $time, what,
               got.r_data, got.r_opc, exp.r_data, exp.r_opc);
      error_count++;
    end
  endtask

  task automatic check_cnt(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      tests_passed++;
      $display("[%0t] %s: passed", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: failed with %0d errors", $time, name, error_count - errs_before);
    end
  endtask

  // starts just after a falling edge and returns on the transfer edge
  task automatic send_req(input core_req_t r);
    req       = r;
    req_valid = 1'b1;
    #1;
    while (!req_ready) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
  endtask

  task automatic wait_rsp(output core_rsp_t r, output int lat);
    @(negedge clk);
    req_valid = 1'b0;
    lat       = 1;
    while (!rsp_valid) begin
      @(negedge clk);
      lat++;
    end
    r = rsp;
  endtask

  task automatic do_req(input logic [`ECC_AW-1:0] add, input logic wen, input logic [7:0] be,
                        input logic [63:0] data, output core_rsp_t r, output int lat);
    @(negedge clk);
    send_req(make_req(add, wen, be, data));
    wait_rsp(r, lat);
  endtask

  task automatic write_word(input logic [`ECC_AW-1:0] add, input logic [7:0] be,
                            input logic [63:0] data);
    core_rsp_t r;
    int        lat;
    do_req(add, 1'b0, be, data, r, lat);
    check_rsp($sformatf("rsp_o (write %h)", add), r, make_rsp('0, OPC_OK));
    model_mem[add] = merge_bytes(model_mem[add], data, be);
  endtask

  task automatic read_word(input logic [`ECC_AW-1:0] add);
    core_rsp_t r;
    int        lat;
    do_req(add, 1'b1, 8'hFF, '0, r, lat);
    check_rsp($sformatf("rsp_o (read %h)", add), r, make_rsp(model_mem[add], OPC_OK));
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [31:0] wdata);
    @(negedge clk);
    reg_req.addr  = addr;
    reg_req.we    = 1'b1;
    reg_req.wdata = wdata;
    reg_valid     = 1'b1;
    @(negedge clk);
    reg_valid  = 1'b0;
    reg_req.we = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_e addr, output logic [31:0] val);
    @(negedge clk);
    reg_req.addr = addr;
    #1;
    val = reg_rdata;
  endtask

  // test 1 uses the lower half of the bank, the others fixed words above it
  task automatic clean_traffic();
    logic [`ECC_AW-1:0] adds [8];
    logic [31:0]        val;
    int                 errs;
    errs = error_count;
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    check_bit("req_ready_o", req_ready, 1'b1);
    for (int i = 0; i < 8; i++) begin
      adds[i] = {1'b0, 9'($random(seed))};
      write_word(adds[i], 8'hFF, {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 8; i++) begin
      read_word(adds[i]);
    end
    reg_read(REG_CNT_SINGLE, val);
    check_cnt("reg_rdata_o (REG_CNT_SINGLE)", val, 32'd0);
    reg_read(REG_CNT_MULTI, val);
    check_cnt("reg_rdata_o (REG_CNT_MULTI)", val, 32'd0);
    reg_read(REG_INJ_DATA, val);
    check_cnt("reg_rdata_o (REG_INJ_DATA)", val, 32'd0);
    reg_read(REG_INJ_META, val);
    check_cnt("reg_rdata_o (REG_INJ_META)", val, 32'd0);
    finish_test("clean_traffic", errs);
  endtask

  task automatic single_data_flip();
    logic [31:0] base;
    logic [31:0] val;
    logic [63:0] d;
    int          errs;
    errs = error_count;
    reg_read(REG_CNT_SINGLE, base);
    reg_write(REG_INJ_DATA, 32'h1 << ($unsigned($random(seed)) % 32));
    d = {$random(seed), $random(seed)};
    write_word(10'h210, 8'hFF, d);
    reg_read(REG_CNT_SINGLE, val);
    check_cnt("reg_rdata_o (REG_CNT_SINGLE)", val, base + 1);
    read_word(10'h210);
    // mask is used up by now
    write_word(10'h210, 8'hFF, ~d);
    reg_read(REG_CNT_SINGLE, val);
    check_cnt("reg_rdata_o (REG_CNT_SINGLE)", val, base + 1);
    read_word(10'h210);
    finish_test("single_data_flip", errs);
  endtask

  task automatic double_data_flip();
    logic [31:0] s0;
    logic [31:0] m0;
    logic [31:0] val;
    int          b1;
    int          b2;
    int          errs;
    errs = error_count;
    reg_read(REG_CNT_SINGLE, s0);
    reg_read(REG_CNT_MULTI, m0);
    b1 = $unsigned($random(seed)) % 32;
    b2 = (b1 + 1 + $unsigned($random(seed)) % 31) % 32;
    reg_write(REG_INJ_DATA, (32'h1 << b1) | (32'h1 << b2));
    // stored word is corrupt and never read back
    write_word(10'h220, 8'hFF, {$random(seed), $random(seed)});
    reg_read(REG_CNT_MULTI, val);
    check_cnt("reg_rdata_o (REG_CNT_MULTI)", val, m0 + 1);
    reg_read(REG_CNT_SINGLE, val);
    check_cnt("reg_rdata_o (REG_CNT_SINGLE)", val, s0);
    finish_test("double_data_flip", errs);
  endtask

  task automatic meta_flip();
    logic [31:0] base;
    logic [31:0] val;
    logic [31:0] mask;
    int          k;
    int          errs;
    errs = error_count;
    reg_read(REG_CNT_SINGLE, base);
    // metadata is {add, wen, be}, so address bits start above wen
    k    = $unsigned($random(seed)) % `ECC_AW;
    mask = 32'h1 << (`ECC_BW + 1 + k);
    reg_write(REG_INJ_META, mask);
    reg_read(REG_INJ_META, val);
    check_cnt("reg_rdata_o (REG_INJ_META)", val, mask);
    write_word(10'h280, 8'hFF, {$random(seed), $random(seed)});
    reg_read(REG_INJ_META, val);
    check_cnt("reg_rdata_o (REG_INJ_META)", val, 32'd0);
    reg_read(REG_CNT_SINGLE, val);
    check_cnt("reg_rdata_o (REG_CNT_SINGLE)", val, base + 1);
    read_word(10'h280);
    finish_test("meta_flip", errs);
  endtask

  task automatic partial_and_range();
    int errs;
    errs = error_count;
    write_word(10'h240, 8'hFF, {$random(seed), $random(seed)});
    write_word(10'h240, 8'h0F, {$random(seed), $random(seed)});
    read_word(10'h240);
    // top word of the default depth still answers OPC_OK
    write_word(10'h3FF, 8'hFF, {$random(seed), $random(seed)});
    read_word(10'h3FF);
    finish_test("partial_and_range", errs);
  endtask

  task automatic back_pressure();
    core_rsp_t   held;
    core_rsp_t   r;
    logic [63:0] d;
    int          lat;
    int          errs;
    errs = error_count;
    d = {$random(seed), $random(seed)};
    write_word(10'h2C0, 8'hFF, d);
    do_req(10'h2C0, 1'b1, 8'hFF, '0, r, lat);
    check_rsp("rsp_o (read 2c0)", r, make_rsp(d, OPC_OK));
    if (lat != 1) begin
      $display("at %0t: response came %0d cycles after the transfer, not one", $time, lat);
      error_count++;
    end
    @(negedge clk);
    rsp_ready = 1'b0;
    send_req(make_req(10'h2C0, 1'b1, 8'hFF, '0));
    wait_rsp(held, lat);
    check_rsp("rsp_o (stalled read)", held, make_rsp(d, OPC_OK));
    // next request waits behind the held response
    req       = make_req(10'h2C4, 1'b0, 8'hFF, ~d);
    req_valid = 1'b1;
    repeat (5) begin
      #1;
      check_rsp("rsp_o (held)", rsp, make_rsp(d, OPC_OK));
      check_bit("rsp_valid_o (held)", rsp_valid, 1'b1);
      check_bit("req_ready_o (held)", req_ready, 1'b0);
      @(negedge clk);
    end
    rsp_ready = 1'b1;
    send_req(make_req(10'h2C4, 1'b0, 8'hFF, ~d));
    wait_rsp(r, lat);
    check_rsp("rsp_o (write after release)", r, make_rsp('0, OPC_OK));
    model_mem[10'h2C4] = ~d;
    read_word(10'h2C4);
    finish_test("back_pressure", errs);
  endtask

  initial begin
    seed      = 32'h26ef2d99;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    reg_req   = '0;
    reg_valid = 1'b0;
    wait (arst_n === 1'b1);
    clean_traffic();
    single_data_flip();
    double_data_flip();
    meta_flip();
    partial_and_range();
    back_pressure();
    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed, tests_failed,
             error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- source/ecc_err_regs.sv
// register block with one-shot fault-injection masks and saturating error counters
`timescale 1ns/1ps
`include "ecc_defines.svh"

module ecc_err_regs (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ecc_pkg::reg_req_t     reg_req_i,
  input  logic                  reg_valid_i,
  output logic [31:0]           reg_rdata_o,
  output logic [`ECC_CHUNK-1:0] inj_data_mask_o,
  output logic [`ECC_METAW-1:0] inj_meta_mask_o,
  input  logic                  inj_used_i,
  input  ecc_pkg::err_info_t    err_i,
  input  logic                  err_valid_i
);

  import ecc_pkg::*;

  logic        wr;
  logic [31:0] cnt_single_q;
  logic [31:0] cnt_multi_q;
  logic [32:0] single_sum;
  logic [32:0] multi_sum;

  assign wr = reg_valid_i & reg_req_i.we;

  // data and meta errors of one request count together
  assign single_sum = {1'b0, cnt_single_q} + 33'(err_i.data_single) + 33'(err_i.meta_single);
  assign multi_sum  = {1'b0, cnt_multi_q} + 33'(err_i.data_multi) + 33'(err_i.meta_multi);

  // a new write arms the mask even if the old one is used on the same edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inj_data_mask_o <= '0;
      inj_meta_mask_o <= '0;
      cnt_single_q    <= '0;
      cnt_multi_q     <= '0;
    end else begin
      if (wr && reg_req_i.addr == REG_INJ_DATA) begin
        inj_data_mask_o <= reg_req_i.wdata[`ECC_CHUNK-1:0];
      end else if (inj_used_i) begin
        inj_data_mask_o <= '0;
      end
      if (wr && reg_req_i.addr == REG_INJ_META) begin
        inj_meta_mask_o <= reg_req_i.wdata[`ECC_METAW-1:0];
      end else if (inj_used_i) begin
        inj_meta_mask_o <= '0;
      end
      // any write clears a counter
      if (wr && reg_req_i.addr == REG_CNT_SINGLE) begin
        cnt_single_q <= '0;
      end else if (err_valid_i) begin
        cnt_single_q <= single_sum[32] ? '1 : single_sum[31:0];
      end
      if (wr && reg_req_i.addr == REG_CNT_MULTI) begin
        cnt_multi_q <= '0;
      end else if (err_valid_i) begin
        cnt_multi_q <= multi_sum[32] ? '1 : multi_sum[31:0];
      end
    end
  end

  always_comb begin
    case (reg_req_i.addr)
      REG_INJ_DATA:   reg_rdata_o = 32'(inj_data_mask_o);
      REG_INJ_META:   reg_rdata_o = 32'(inj_meta_mask_o);
      REG_CNT_SINGLE: reg_rdata_o = cnt_single_q;
      default:        reg_rdata_o = cnt_multi_q;
    endcase
  end

endmodule

//--- source/ecc_initiator_bridge.sv
// core-side bridge, encodes requests with optional fault injection and corrects response data
`timescale 1ns/1ps
`include "ecc_defines.svh"

module ecc_initiator_bridge (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ecc_pkg::core_req_t    req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output ecc_pkg::prot_req_t    preq_o,
  output logic                  preq_valid_o,
  input  logic                  preq_ready_i,
  input  ecc_pkg::prot_rsp_t    prsp_i,
  input  logic                  prsp_valid_i,
  output logic                  prsp_ready_o,
  output ecc_pkg::core_rsp_t    rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  input  logic [`ECC_CHUNK-1:0] inj_data_mask_i,
  input  logic [`ECC_METAW-1:0] inj_meta_mask_i,
  output logic                  inj_used_o
);

  logic                                      hold_q;
  logic [`ECC_CHUNK-1:0]                     data_mask_q;
  logic [`ECC_CHUNK-1:0]                     data_mask;
  logic [`ECC_METAW-1:0]                     meta_mask_q;
  logic [`ECC_METAW-1:0]                     meta_mask;
  logic [`ECC_METAW-1:0]                     meta;
  logic [`ECC_NCHUNK-1:0][`ECC_EW_CHUNK-1:0] data_ecc;
  logic [`ECC_EW_META-1:0]                   meta_ecc;
  logic [`ECC_NCHUNK-1:0][`ECC_CHUNK-1:0]    r_data_dec;

  assign meta = {req_i.add, req_i.wen, req_i.be};

  for (genvar i = 0; i < `ECC_NCHUNK; i++) begin : g_data_enc
    secded_enc #(.K(`ECC_CHUNK), .R(`ECC_EW_CHUNK)) i_data_enc (
      .data_i ( req_i.data[i*`ECC_CHUNK +: `ECC_CHUNK] ),
      .ecc_o  ( data_ecc[i]                           )
    );
  end

  secded_enc #(.K(`ECC_METAW), .R(`ECC_EW_META)) i_meta_enc (
    .data_i ( meta     ),
    .ecc_o  ( meta_ecc )
  );

  // a waiting request keeps the mask it was first presented with
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= req_valid_i & ~preq_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hold_q) begin
      data_mask_q <= inj_data_mask_i;
      meta_mask_q <= inj_meta_mask_i;
    end
  end

  assign data_mask = hold_q ? data_mask_q : inj_data_mask_i;
  assign meta_mask = hold_q ? meta_mask_q : inj_meta_mask_i;

  // flips go in after encoding so they look like channel faults
  always_comb begin
    preq_o.req                           = req_i;
    {preq_o.req.add, preq_o.req.wen, preq_o.req.be} = meta ^ meta_mask;
    preq_o.req.data[`ECC_CHUNK-1:0]      = req_i.data[`ECC_CHUNK-1:0] ^ data_mask;
    preq_o.ecc.data                      = data_ecc;
    preq_o.ecc.meta                      = meta_ecc;
  end

  for (genvar i = 0; i < `ECC_NCHUNK; i++) begin : g_rsp_dec
    secded_dec #(.K(`ECC_CHUNK), .R(`ECC_EW_CHUNK)) i_rsp_dec (
      .data_i       ( prsp_i.rsp.r_data[i*`ECC_CHUNK +: `ECC_CHUNK] ),
      .ecc_i        ( prsp_i.r_ecc[i]                              ),
      .data_o       ( r_data_dec[i]                                ),
      .single_err_o (                                              ),
      .multi_err_o  (                                              )
    );
  end

  assign rsp_o.r_data = r_data_dec;
  assign rsp_o.r_opc  = prsp_i.rsp.r_opc;

  assign preq_valid_o = req_valid_i;
  assign req_ready_o  = preq_ready_i;
  assign rsp_valid_o  = prsp_valid_i;
  assign prsp_ready_o = rsp_ready_i;
  assign inj_used_o   = req_valid_i & preq_ready_i;

endmodule

//--- source/ecc_pkg.sv
// request, response, register and error-report types shared by the bridges, bank and registers
`include "ecc_defines.svh"

package ecc_pkg;

  typedef enum logic {
    OPC_OK    = 1'b0,
    OPC_RANGE = 1'b1
  } rsp_opc_e;

  typedef enum logic [1:0] {
    REG_INJ_DATA   = 2'd0,
    REG_INJ_META   = 2'd1,
    REG_CNT_SINGLE = 2'd2,
    REG_CNT_MULTI  = 2'd3
  } reg_addr_e;

  // wen high is a read, low a write, as on the TCDM bus
  typedef struct packed {
    logic [`ECC_AW-1:0] add;
    logic               wen;
    logic [`ECC_BW-1:0] be;
    logic [`ECC_DW-1:0] data;
  } core_req_t;

  typedef struct packed {
    logic [`ECC_DW-1:0] r_data;
    rsp_opc_e           r_opc;
  } core_rsp_t;

  // chunk 0 sits in the low index
  typedef struct packed {
    logic [`ECC_NCHUNK-1:0][`ECC_EW_CHUNK-1:0] data;
    logic [`ECC_EW_META-1:0]                   meta;
  } req_ecc_t;

  typedef struct packed {
    core_req_t req;
    req_ecc_t  ecc;
  } prot_req_t;

  typedef struct packed {
    core_rsp_t                                 rsp;
    logic [`ECC_NCHUNK-1:0][`ECC_EW_CHUNK-1:0] r_ecc;
  } prot_rsp_t;

  typedef struct packed {
    reg_addr_e   addr;
    logic        we;
    logic [31:0] wdata;
  } reg_req_t;

  // data fields count chunks, meta fields are flags
  typedef struct packed {
    logic [1:0] data_single;
    logic [1:0] data_multi;
    logic       meta_single;
    logic       meta_multi;
  } err_info_t;

endpackage

//--- source/ecc_target_bridge.sv
// bank-side bridge, corrects protected requests, protects response data and reports errors
`timescale 1ns/1ps
`include "ecc_defines.svh"

module ecc_target_bridge (
  input  ecc_pkg::prot_req_t preq_i,
  input  logic               preq_valid_i,
  output logic               preq_ready_o,
  output ecc_pkg::core_req_t req_o,
  output logic               req_valid_o,
  input  logic               req_ready_i,
  input  ecc_pkg::core_rsp_t rsp_i,
  input  logic               rsp_valid_i,
  output logic               rsp_ready_o,
  output ecc_pkg::prot_rsp_t prsp_o,
  output logic               prsp_valid_o,
  input  logic               prsp_ready_i,
  output ecc_pkg::err_info_t err_o,
  output logic               err_valid_o
);

  logic [`ECC_NCHUNK-1:0][`ECC_CHUNK-1:0]    data_dec;
  logic [`ECC_NCHUNK-1:0]                    data_single;
  logic [`ECC_NCHUNK-1:0]                    data_multi;
  logic [`ECC_METAW-1:0]                     meta_dec;
  logic                                      meta_single;
  logic                                      meta_multi;
  logic [`ECC_NCHUNK-1:0][`ECC_EW_CHUNK-1:0] r_ecc;

  for (genvar i = 0; i < `ECC_NCHUNK; i++) begin : g_data_dec
    secded_dec #(.K(`ECC_CHUNK), .R(`ECC_EW_CHUNK)) i_data_dec (
      .data_i       ( preq_i.req.data[i*`ECC_CHUNK +: `ECC_CHUNK] ),
      .ecc_i        ( preq_i.ecc.data[i]                         ),
      .data_o       ( data_dec[i]                                ),
      .single_err_o ( data_single[i]                             ),
      .multi_err_o  ( data_multi[i]                              )
    );
  end

  // address, wen and be share one code word
  secded_dec #(.K(`ECC_METAW), .R(`ECC_EW_META)) i_meta_dec (
    .data_i       ( {preq_i.req.add, preq_i.req.wen, preq_i.req.be} ),
    .ecc_i        ( preq_i.ecc.meta                                 ),
    .data_o       ( meta_dec                                        ),
    .single_err_o ( meta_single                                     ),
    .multi_err_o  ( meta_multi                                      )
  );

  for (genvar i = 0; i < `ECC_NCHUNK; i++) begin : g_rsp_enc
    secded_enc #(.K(`ECC_CHUNK), .R(`ECC_EW_CHUNK)) i_rsp_enc (
      .data_i ( rsp_i.r_data[i*`ECC_CHUNK +: `ECC_CHUNK] ),
      .ecc_o  ( r_ecc[i]                                )
    );
  end

  assign {req_o.add, req_o.wen, req_o.be} = meta_dec;
  assign req_o.data                       = data_dec;

  assign prsp_o.rsp   = rsp_i;
  assign prsp_o.r_ecc = r_ecc;

  // a multi error is only reported, the request still goes to the bank
  assign err_o.data_single = 2'($countones(data_single));
  assign err_o.data_multi  = 2'($countones(data_multi));
  assign err_o.meta_single = meta_single;
  assign err_o.meta_multi  = meta_multi;
  assign err_valid_o       = preq_valid_i & req_ready_i;

  assign req_valid_o  = preq_valid_i;
  assign preq_ready_o = req_ready_i;
  assign prsp_valid_o = rsp_valid_i;
  assign rsp_ready_o  = prsp_ready_i;

endmodule

//--- source/secded_dec.sv
// extended Hamming decoder, corrects one flipped bit and flags single and multi errors
`timescale 1ns/1ps
`include "ecc_defines.svh"

module secded_dec #(
  parameter int unsigned K = `ECC_CHUNK,
  parameter int unsigned R = `ECC_EW_CHUNK
) (
  input  logic [K-1:0] data_i,
  input  logic [R-1:0] ecc_i,
  output logic [K-1:0] data_o,
  output logic         single_err_o,
  output logic         multi_err_o
);

  localparam int unsigned P = R - 1;
  localparam int unsigned N = K + P;

  logic [N:1]   cw;
  logic [P-1:0] syn;
  logic         odd;

  assign odd = ^{data_i, ecc_i};

  always_comb begin
    int unsigned d;
    int unsigned h;
    cw = '0;
    d  = 0;
    h  = 0;
    // rebuild the codeword, check bits at powers of two
    for (int unsigned pos = 1; pos <= N; pos++) begin
      if ((pos & (pos - 1)) == 0) begin
        cw[pos] = ecc_i[h];
        h++;
      end else begin
        cw[pos] = data_i[d];
        d++;
      end
    end
    syn = '0;
    for (int unsigned p = 0; p < P; p++) begin
      for (int unsigned pos = 1; pos <= N; pos++) begin
        if (pos[p]) begin
          syn[p] ^= cw[pos];
        end
      end
    end
    single_err_o = 1'b0;
    multi_err_o  = 1'b0;
    if (syn != '0 && odd && syn <= N) begin
      cw[syn]      = ~cw[syn];
      single_err_o = 1'b1;
    end else if (syn != '0) begin
      // even parity, or a syndrome pointing outside the word
      multi_err_o = 1'b1;
    end else if (odd) begin
      // only the overall bit flipped
      single_err_o = 1'b1;
    end
    d = 0;
    for (int unsigned pos = 1; pos <= N; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data_o[d] = cw[pos];
        d++;
      end
    end
  end

endmodule

//--- source/secded_enc.sv
// extended Hamming encoder, one instance per protected field produces that field's check bits
`timescale 1ns/1ps
`include "ecc_defines.svh"

module secded_enc #(
  parameter int unsigned K = `ECC_CHUNK,
  parameter int unsigned R = `ECC_EW_CHUNK
) (
  input  logic [K-1:0] data_i,
  output logic [R-1:0] ecc_o
);

  // R-1 Hamming bits, top bit is overall parity
  localparam int unsigned P = R - 1;
  localparam int unsigned N = K + P;

  logic [N:1]   cw;
  logic [P-1:0] ham;

  always_comb begin
    int unsigned d;
    cw = '0;
    d  = 0;
    // data fills positions that are not powers of two
    for (int unsigned pos = 1; pos <= N; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        cw[pos] = data_i[d];
        d++;
      end
    end
    for (int unsigned p = 0; p < P; p++) begin
      ham[p] = 1'b0;
      for (int unsigned pos = 1; pos <= N; pos++) begin
        if (pos[p]) begin
          ham[p] ^= cw[pos];
        end
      end
    end
  end

  // overall bit makes the whole codeword even
  assign ecc_o = {^{data_i, ham}, ham};

endmodule

//--- source/tcdm_bank.sv
// single-port memory bank with byte enables and a one-deep registered response
`timescale 1ns/1ps
`include "ecc_defines.svh"

module tcdm_bank #(
  parameter int unsigned DEPTH = 1024
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  ecc_pkg::core_req_t req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output ecc_pkg::core_rsp_t rsp_o,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i
);

  import ecc_pkg::*;

  logic [`ECC_DW-1:0] mem [DEPTH];
  logic               accept;
  logic               in_range;
  logic               rsp_valid_q;
  core_rsp_t          rsp_q;

  // free slot, or the held response leaves this cycle
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;
  assign in_range    = req_i.add < DEPTH;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.r_opc  <= in_range ? OPC_OK : OPC_RANGE;
      rsp_q.r_data <= '0;
      if (in_range && req_i.wen) begin
        rsp_q.r_data <= mem[req_i.add];
      end
      if (in_range && !req_i.wen) begin
        for (int b = 0; b < `ECC_BW; b++) begin
          if (req_i.be[b]) begin
            mem[req_i.add][b*8 +: 8] <= req_i.data[b*8 +: 8];
          end
        end
      end
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

//--- source/tcdm_ecc_top.sv
// top level of the ECC-protected TCDM path, joins the bridges, the bank and the register block
`timescale 1ns/1ps
`include "ecc_defines.svh"

module tcdm_ecc_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  ecc_pkg::core_req_t req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output ecc_pkg::core_rsp_t rsp_o,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  input  ecc_pkg::reg_req_t  reg_req_i,
  input  logic               reg_valid_i,
  output logic [31:0]        reg_rdata_o
);

  import ecc_pkg::*;

  prot_req_t             preq;
  logic                  preq_valid;
  logic                  preq_ready;
  prot_rsp_t             prsp;
  logic                  prsp_valid;
  logic                  prsp_ready;
  core_req_t             bank_req;
  logic                  bank_req_valid;
  logic                  bank_req_ready;
  core_rsp_t             bank_rsp;
  logic                  bank_rsp_valid;
  logic                  bank_rsp_ready;
  logic [`ECC_CHUNK-1:0] inj_data_mask;
  logic [`ECC_METAW-1:0] inj_meta_mask;
  logic                  inj_used;
  err_info_t             err;
  logic                  err_valid;

  ecc_initiator_bridge i_init (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .req_i           ( req_i         ),
    .req_valid_i     ( req_valid_i   ),
    .req_ready_o     ( req_ready_o   ),
    .preq_o          ( preq          ),
    .preq_valid_o    ( preq_valid    ),
    .preq_ready_i    ( preq_ready    ),
    .prsp_i          ( prsp          ),
    .prsp_valid_i    ( prsp_valid    ),
    .prsp_ready_o    ( prsp_ready    ),
    .rsp_o           ( rsp_o         ),
    .rsp_valid_o     ( rsp_valid_o   ),
    .rsp_ready_i     ( rsp_ready_i   ),
    .inj_data_mask_i ( inj_data_mask ),
    .inj_meta_mask_i ( inj_meta_mask ),
    .inj_used_o      ( inj_used      )
  );

  // the protected link between the two bridges
  ecc_target_bridge i_target (
    .preq_i       ( preq           ),
    .preq_valid_i ( preq_valid     ),
    .preq_ready_o ( preq_ready     ),
    .req_o        ( bank_req       ),
    .req_valid_o  ( bank_req_valid ),
    .req_ready_i  ( bank_req_ready ),
    .rsp_i        ( bank_rsp       ),
    .rsp_valid_i  ( bank_rsp_valid ),
    .rsp_ready_o  ( bank_rsp_ready ),
    .prsp_o       ( prsp           ),
    .prsp_valid_o ( prsp_valid     ),
    .prsp_ready_i ( prsp_ready     ),
    .err_o        ( err            ),
    .err_valid_o  ( err_valid      )
  );

  tcdm_bank #(.DEPTH(1024)) i_bank (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .req_i       ( bank_req       ),
    .req_valid_i ( bank_req_valid ),
    .req_ready_o ( bank_req_ready ),
    .rsp_o       ( bank_rsp       ),
    .rsp_valid_o ( bank_rsp_valid ),
    .rsp_ready_i ( bank_rsp_ready )
  );

  ecc_err_regs i_regs (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .reg_req_i       ( reg_req_i     ),
    .reg_valid_i     ( reg_valid_i   ),
    .reg_rdata_o     ( reg_rdata_o   ),
    .inj_data_mask_o ( inj_data_mask ),
    .inj_meta_mask_o ( inj_meta_mask ),
    .inj_used_i      ( inj_used      ),
    .err_i           ( err           ),
    .err_valid_i     ( err_valid     )
  );

endmodule
